//--- compile.f
pocket_core_pkg.sv
core_settings_if.sv
player_input_if.sv
bridge_reg_decode.sv
core_reset_stretch.sv
controller_route.sv
control_panel_encode.sv
pocket_core_top.sv
tb_pocket_core.sv

//--- Bender.yml
package:
  name: pocket_core

sources:
  - files:
      - pocket_core_pkg.sv
      - core_settings_if.sv
      - player_input_if.sv
      - bridge_reg_decode.sv
      - core_reset_stretch.sv
      - controller_route.sv
      - control_panel_encode.sv
      - pocket_core_top.sv
  - target: test
    files:
      - tb_pocket_core.sv

//--- tb_pocket_core.sv
// Testbench for the pocket core front end.
// Drives the host bridge and both pad sources, predicts register read-back,
// the core reset hold and the control panel, and checks them with assertions.

`timescale 1ns/1ns

module tb_pocket_core import pocket_core_pkg::*; ();

    // longest wait for core_run is the hold count plus margin
    localparam int RUN_TIMEOUT = 9000;

    logic           clk_sys;
    logic           temp_reset;
    bridge_addr_t   bridge_addr;
    logic           bridge_rd;
    logic           bridge_wr;
    bridge_data_t   bridge_wr_data;
    bridge_data_t   bridge_rd_data;
    cont_key_t      cont1_key;
    cont_key_t      cont2_key;
    cont_joy_t      cont1_joy;
    cont_joy_t      cont2_joy;
    pad_btn_t       snac_p1_btn;
    pad_btn_t       snac_p2_btn;
    cont_joy_t      snac_p1_stick;
    cont_joy_t      snac_p2_stick;
    logic           core_run;
    dip_t           dip_sw0;
    dip_t           dip_sw1;
    mode_t          core_mode;
    control_panel_t control_panel;

    // snac fields as last written feed the panel model
    snac_type_t   cur_type;
    snac_assign_t cur_assign;

    int checks;
    int value_errors;
    int timeouts;

    pocket_core_top u_dut (
        .clk_sys        (clk_sys),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .cont1_joy      (cont1_joy),
        .cont2_joy      (cont2_joy),
        .snac_p1_btn    (snac_p1_btn),
        .snac_p2_btn    (snac_p2_btn),
        .snac_p1_stick  (snac_p1_stick),
        .snac_p2_stick  (snac_p2_stick),
        .core_run       (core_run),
        .dip_sw0        (dip_sw0),
        .dip_sw1        (dip_sw1),
        .core_mode      (core_mode),
        .control_panel  (control_panel)
    );

    // 8 ns clock
    initial begin
        clk_sys = 1'b0;
        forever begin
            #4 clk_sys = ~clk_sys;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    // {up, down, left, right} for one player
    function automatic logic [3:0] direction_bits(input cont_key_t key, input cont_joy_t joy,
                                                  input logic analog);
        stick_axis_t x;
        stick_axis_t y;
        x = joy[7:0];
        y = joy[15:8];
        if (analog) begin
            return {(y < STICK_LOW), (y > STICK_HIGH), (x < STICK_LOW), (x > STICK_HIGH)};
        end
        return {key[BTN_UP], key[BTN_DOWN], key[BTN_LEFT], key[BTN_RIGHT]};
    endfunction

    function automatic control_panel_t merge_players(input cont_key_t k1, input cont_joy_t j1,
                                                     input cont_key_t k2, input cont_joy_t j2,
                                                     input logic analog);
        control_panel_t pressed;
        pressed[8]   = k1[BTN_SELECT] | k2[BTN_SELECT];
        pressed[7]   = k2[BTN_START];
        pressed[6]   = k1[BTN_START];
        pressed[5]   = k1[BTN_B] | k2[BTN_B];
        pressed[4]   = k1[BTN_A] | k2[BTN_A];
        pressed[3:0] = direction_bits(k1, j1, analog) | direction_bits(k2, j2, analog);
        // active low on the panel
        return ~pressed;
    endfunction

    // panel expected from the current tb inputs and snac settings
    function automatic control_panel_t predict_panel();
        cont_key_t s1_key;
        cont_key_t s2_key;
        cont_joy_t pocket1_stick;
        cont_joy_t pocket2_stick;
        logic      analog;
        s1_key        = {16'd0, snac_p1_btn};
        s2_key        = {16'd0, snac_p2_btn};
        pocket1_stick = (cont1_key[31:28] == KEY_TYPE_ANALOG) ? cont1_joy : JOY_NEUTRAL;
        pocket2_stick = (cont2_key[31:28] == KEY_TYPE_ANALOG) ? cont2_joy : JOY_NEUTRAL;
        analog        = (cur_type == SNAC_ANALOG_TYPE);
        if (cur_type == SNAC_DISABLED) begin
            return merge_players(cont1_key, cont1_joy, cont2_key, cont2_joy, analog);
        end
        case (cur_assign)
            4'd0: return merge_players(s1_key, snac_p1_stick, cont2_key, pocket2_stick, analog);
            4'd1: return merge_players(cont1_key, pocket1_stick, s1_key, snac_p1_stick, analog);
            4'd2: return merge_players(s1_key, snac_p1_stick, s2_key, snac_p2_stick, analog);
            4'd3: return merge_players(s2_key, snac_p2_stick, s1_key, snac_p1_stick, analog);
            default: return merge_players(cont1_key, pocket1_stick, cont2_key, pocket2_stick,
                                          analog);
        endcase
    endfunction

    // threshold probes around STICK_LOW and STICK_HIGH
    function automatic stick_axis_t stick_level(input int idx);
        case (idx)
            0: return 8'h00;
            1: return 8'h3F;
            2: return 8'h40;
            3: return 8'h80;
            4: return 8'hC0;
            5: return 8'hC1;
            default: return 8'hFF;
        endcase
    endfunction

    ////////////////////
    // check helpers
    ////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
        @(posedge clk_sys);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        // dut takes the strobe on this edge
        @(posedge clk_sys);
        bridge_wr <= 1'b0;
    endtask

    task automatic bus_read_check(input string name, input bridge_addr_t addr,
                                  input bridge_data_t expected);
        @(posedge clk_sys);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        // buffer loads here and the address stays for the data phase
        @(posedge clk_sys);
        bridge_rd <= 1'b0;
        @(negedge clk_sys);
        check_value(name, expected, bridge_rd_data);
    endtask

    task automatic set_snac(input snac_type_t stype, input snac_assign_t sassign);
        // type in bits 4:0, assignment in bits 9:6
        bus_write(ADDR_SNAC, {22'd0, sassign, 1'b0, stype});
        cur_type   = stype;
        cur_assign = sassign;
    endtask

    task automatic drive_pads(input cont_key_t k1, input cont_key_t k2,
                              input cont_joy_t j1, input cont_joy_t j2);
        logic [31:0] btns;
        btns = $urandom();
        @(posedge clk_sys);
        cont1_key     <= k1;
        cont2_key     <= k2;
        cont1_joy     <= j1;
        cont2_joy     <= j2;
        snac_p1_btn   <= btns[15:0];
        snac_p2_btn   <= btns[31:16];
        snac_p1_stick <= $urandom();
        snac_p2_stick <= $urandom();
    endtask

    // route stage, then encode stage, then a stable sample
    task automatic check_panel(input string name);
        @(posedge clk_sys);
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value(name, {23'd0, predict_panel()}, {23'd0, control_panel});
    endtask

    task automatic random_pad_round(input string name);
        drive_pads($urandom(), $urandom(), $urandom(), $urandom());
        check_panel(name);
    endtask

    task automatic wait_core_run(input string cause);
        int cycles;
        cycles = 0;
        while (core_run !== 1'b1 && cycles < RUN_TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (core_run !== 1'b1) begin
            timeouts++;
            $display("timeout: core_run never came back after %s", cause);
        end
    endtask

    // called right after the strobe edge of the write
    // cycles counts clock edges since that strobe edge
    task automatic check_reset_stretch(input string cause);
        int   cycles;
        logic risen;
        cycles = 0;
        risen  = 1'b0;
        // half a cycle past the strobe edge
        @(negedge clk_sys);
        while (!risen && cycles < RUN_TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles == 2) begin
                check_value({"core_run after ", cause}, 32'd0, {31'd0, core_run});
            end
            if (cycles > 2) begin
                risen = (core_run === 1'b1);
            end
        end
        if (!risen) begin
            timeouts++;
            $display("timeout: core_run stayed low after %s", cause);
        end else begin
            checks++;
            assert (cycles >= int'(RESET_HOLD_CYCLES) && cycles <= int'(RESET_HOLD_CYCLES) + 3)
            else begin
                value_errors++;
                $display("ERR t=%0t core_run rise after %s expected %0d..%0d actual %0d",
                         $time, cause, RESET_HOLD_CYCLES, RESET_HOLD_CYCLES + 3, cycles);
            end
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        bridge_data_t dip_word;
        bridge_data_t mode_word;
        bridge_data_t snac_word;
        logic [31:0]  rnd;
        cont_joy_t    j1;
        cont_joy_t    j2;
        key_type_t    ktype;

        void'($urandom(32'h8864));
        checks         = 0;
        value_errors   = 0;
        timeouts       = 0;
        cur_type       = SNAC_DISABLED;
        cur_assign     = '0;
        temp_reset     = 1'b1;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        cont1_joy      = '0;
        cont2_joy      = '0;
        snac_p1_btn    = '0;
        snac_p2_btn    = '0;
        snac_p1_stick  = '0;
        snac_p2_stick  = '0;

        repeat (2) @(posedge clk_sys);
        temp_reset <= 1'b0;
        @(negedge clk_sys);
        check_value("control_panel idle", 32'h1FF, {23'd0, control_panel});
        wait_core_run("temp_reset");

        // register read-back
        repeat (3) begin
            dip_word  = $urandom();
            mode_word = $urandom();
            snac_word = $urandom();
            bus_write(ADDR_DIP, dip_word);
            bus_write(ADDR_MODE, mode_word);
            bus_write(ADDR_SNAC, snac_word);
            @(negedge clk_sys);
            check_value("dip_sw0", {24'd0, dip_word[7:0]}, {24'd0, dip_sw0});
            check_value("dip_sw1", {24'd0, dip_word[15:8]}, {24'd0, dip_sw1});
            check_value("core_mode", {24'd0, mode_word[7:0]}, {24'd0, core_mode});
            bus_read_check("bridge_rd_data dip", ADDR_DIP, dip_word);
            bus_read_check("bridge_rd_data mode", ADDR_MODE, mode_word);
            bus_read_check("bridge_rd_data snac", ADDR_SNAC, {18'd0, snac_word[13:0]});
            // mapped slots have bit 0 clear
            rnd = $urandom();
            bus_read_check("bridge_rd_data unmapped", rnd | 32'h1, 32'd0);
        end

        // reset stretch after a command and after a dip write
        wait_core_run("dip read-back");
        bus_write(ADDR_RESET, 32'h1);
        check_reset_stretch("reset command");
        bus_read_check("bridge_rd_data reset running", ADDR_RESET, 32'd1);
        bus_write(ADDR_DIP, $urandom());
        check_reset_stretch("dip write");
        bus_write(ADDR_RESET, 32'h1);
        bus_read_check("bridge_rd_data reset held", ADDR_RESET, 32'd0);
        wait_core_run("held read");

        // pocket pads straight through
        set_snac(SNAC_DISABLED, 4'd0);
        repeat (20) random_pad_round("control_panel pocket");

        // snac routing with a digital pad type
        for (int code = 0; code < 5; code++) begin
            set_snac(5'h01, (code < 4) ? 4'(code) : 4'd9);
            repeat (10) random_pad_round("control_panel snac route");
        end

        // left stick as d-pad for analog and digital pocket key types
        set_snac(SNAC_ANALOG_TYPE, 4'hF);
        for (int pass = 0; pass < 2; pass++) begin
            ktype = (pass == 0) ? KEY_TYPE_ANALOG : 4'h5;
            for (int xi = 0; xi < 7; xi++) begin
                for (int yi = 0; yi < 7; yi++) begin
                    rnd = $urandom();
                    j1  = {rnd[31:16], stick_level(yi), stick_level(xi)};
                    j2  = {rnd[15:0], stick_level(xi), stick_level(yi)};
                    drive_pads({ktype, rnd[27:0]}, {ktype, rnd[11:0], rnd[31:16]}, j1, j2);
                    check_panel("control_panel analog stick");
                end
            end
        end

        repeat (2) @(posedge clk_sys);
        $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- pocket_core_top.sv
// Top level of the host bridge and controller front end.
// Ties the register decode, reset stretch, routing and panel encoder
// together; everything runs on clk_sys.

`timescale 1ns/1ns

module pocket_core_top import pocket_core_pkg::*; (
    input  logic           clk_sys,
    input  logic           temp_reset,
    // host bridge
    input  bridge_addr_t   bridge_addr,
    input  logic           bridge_rd,
    input  logic           bridge_wr,
    input  bridge_data_t   bridge_wr_data,
    output bridge_data_t   bridge_rd_data,
    // pocket pads
    input  cont_key_t      cont1_key,
    input  cont_key_t      cont2_key,
    input  cont_joy_t      cont1_joy,
    input  cont_joy_t      cont2_joy,
    // snac adapter pads
    input  pad_btn_t       snac_p1_btn,
    input  pad_btn_t       snac_p2_btn,
    input  cont_joy_t      snac_p1_stick,
    input  cont_joy_t      snac_p2_stick,
    // to the core
    output logic           core_run,
    output dip_t           dip_sw0,
    output dip_t           dip_sw1,
    output mode_t          core_mode,
    output control_panel_t control_panel
);

    core_settings_if settings_bus ();
    player_input_if  player_bus ();

    ////////////////////
    // bridge side
    ////////////////////
    bridge_reg_decode u_decode (
        .clk_sys        (clk_sys),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .core_run       (core_run),
        .bridge_rd_data (bridge_rd_data),
        .settings       (settings_bus.decoder)
    );

    core_reset_stretch u_reset (
        .clk_sys    (clk_sys),
        .temp_reset (temp_reset),
        .settings   (settings_bus.reset_user),
        .core_run   (core_run)
    );

    ////////////////////
    // controller side
    ////////////////////
    controller_route u_route (
        .clk_sys       (clk_sys),
        .temp_reset    (temp_reset),
        .cont1_key     (cont1_key),
        .cont2_key     (cont2_key),
        .cont1_joy     (cont1_joy),
        .cont2_joy     (cont2_joy),
        .snac_p1_btn   (snac_p1_btn),
        .snac_p2_btn   (snac_p2_btn),
        .snac_p1_stick (snac_p1_stick),
        .snac_p2_stick (snac_p2_stick),
        .settings      (settings_bus.pad_user),
        .players       (player_bus.router)
    );

    control_panel_encode u_encode (
        .clk_sys       (clk_sys),
        .temp_reset    (temp_reset),
        .settings      (settings_bus.pad_user),
        .players       (player_bus.encoder),
        .control_panel (control_panel)
    );

    // settings straight out to the core
    assign dip_sw0   = settings_bus.dip_sw0;
    assign dip_sw1   = settings_bus.dip_sw1;
    assign core_mode = settings_bus.core_mode;

endmodule

//--- control_panel_encode.sv
// Decodes both players into the active-low nine-bit control panel.
// Directions come from the d-pad, or from the left stick when the SNAC
// type selects the analog pad.

`timescale 1ns/1ns

module control_panel_encode import pocket_core_pkg::*; (
    input  logic                clk_sys,
    input  logic                temp_reset,
    core_settings_if.pad_user   settings,
    player_input_if.encoder     players,
    output control_panel_t      control_panel
);

    // returns {up, down, left, right}
    function automatic logic [3:0] player_dirs(
        input cont_key_t key,
        input cont_joy_t joy,
        input logic      use_stick
    );
        stick_axis_t x;
        stick_axis_t y;
        x = joy[7:0];
        y = joy[15:8];
        if (use_stick) begin
            return {(y < STICK_LOW), (y > STICK_HIGH), (x < STICK_LOW), (x > STICK_HIGH)};
        end
        return {key[BTN_UP], key[BTN_DOWN], key[BTN_LEFT], key[BTN_RIGHT]};
    endfunction

    logic           use_stick;
    logic [3:0]     p1_dir;
    logic [3:0]     p2_dir;
    logic           coin;
    logic           shoot;
    logic           shoot2;
    control_panel_t panel_next;

    ////////////////////
    // decode and merge
    ////////////////////
    assign use_stick = (settings.snac_type == SNAC_ANALOG_TYPE);
    assign p1_dir    = player_dirs(players.p1_key, players.p1_joy, use_stick);
    assign p2_dir    = player_dirs(players.p2_key, players.p2_joy, use_stick);

    // either player may coin up or fire
    assign coin   = players.p1_key[BTN_SELECT] | players.p2_key[BTN_SELECT];
    assign shoot  = players.p1_key[BTN_A] | players.p2_key[BTN_A];
    assign shoot2 = players.p1_key[BTN_B] | players.p2_key[BTN_B];

    // start buttons stay per player
    assign panel_next = {
        coin,
        players.p2_key[BTN_START],
        players.p1_key[BTN_START],
        shoot2,
        shoot,
        p1_dir | p2_dir
    };

    // panel is active low, all ones is idle
    always_ff @(posedge clk_sys) begin
        if (temp_reset) begin
            control_panel <= '1;
        end else begin
            control_panel <= ~panel_next;
        end
    end

endmodule

//--- controller_route.sv
// Chooses pocket or SNAC adapter pads for player 1 and player 2.
// Routing follows the SNAC assignment code; pocket sticks without an
// analog source read as centred while the adapter is enabled.

`timescale 1ns/1ns

module controller_route import pocket_core_pkg::*; (
    input  logic                clk_sys,
    input  logic                temp_reset,
    input  cont_key_t           cont1_key,
    input  cont_key_t           cont2_key,
    input  cont_joy_t           cont1_joy,
    input  cont_joy_t           cont2_joy,
    input  pad_btn_t            snac_p1_btn,
    input  pad_btn_t            snac_p2_btn,
    input  cont_joy_t           snac_p1_stick,
    input  cont_joy_t           snac_p2_stick,
    core_settings_if.pad_user   settings,
    player_input_if.router      players
);

    // pocket stick only counts on an analog pad
    function automatic cont_joy_t pocket_stick(input cont_key_t key, input cont_joy_t joy);
        return (key[31:28] == KEY_TYPE_ANALOG) ? joy : JOY_NEUTRAL;
    endfunction

    cont_key_t snac1_key;
    cont_key_t snac2_key;
    cont_joy_t pocket1_joy;
    cont_joy_t pocket2_joy;

    // snac buttons fill the low half, type bits zero
    assign snac1_key   = {16'd0, snac_p1_btn};
    assign snac2_key   = {16'd0, snac_p2_btn};
    assign pocket1_joy = pocket_stick(cont1_key, cont1_joy);
    assign pocket2_joy = pocket_stick(cont2_key, cont2_joy);

    ////////////////////
    // routing register
    ////////////////////
    always_ff @(posedge clk_sys) begin
        if (temp_reset) begin
            players.p1_key <= '0;
            players.p1_joy <= JOY_NEUTRAL;
            players.p2_key <= '0;
            players.p2_joy <= JOY_NEUTRAL;
        end else if (settings.snac_type == SNAC_DISABLED) begin
            // adapter off, pocket pads untouched
            players.p1_key <= cont1_key;
            players.p1_joy <= cont1_joy;
            players.p2_key <= cont2_key;
            players.p2_joy <= cont2_joy;
        end else begin
            case (settings.snac_assign)
                4'd0: begin
                    // snac on p1, pocket pad 2 on p2
                    players.p1_key <= snac1_key;
                    players.p1_joy <= snac_p1_stick;
                    players.p2_key <= cont2_key;
                    players.p2_joy <= pocket2_joy;
                end
                4'd1: begin
                    // pocket pad 1 on p1, snac on p2
                    players.p1_key <= cont1_key;
                    players.p1_joy <= pocket1_joy;
                    players.p2_key <= snac1_key;
                    players.p2_joy <= snac_p1_stick;
                end
                4'd2: begin
                    players.p1_key <= snac1_key;
                    players.p1_joy <= snac_p1_stick;
                    players.p2_key <= snac2_key;
                    players.p2_joy <= snac_p2_stick;
                end
                4'd3: begin
                    // both snac pads, swapped
                    players.p1_key <= snac2_key;
                    players.p1_joy <= snac_p2_stick;
                    players.p2_key <= snac1_key;
                    players.p2_joy <= snac_p1_stick;
                end
                default: begin
                    players.p1_key <= cont1_key;
                    players.p1_joy <= pocket1_joy;
                    players.p2_key <= cont2_key;
                    players.p2_joy <= pocket2_joy;
                end
            endcase
        end
    end

endmodule

//--- core_reset_stretch.sv
// Holds the core in reset for a fixed count after a restart strobe.
// core_run goes high once the hold counter has run down to zero.

`timescale 1ns/1ns

module core_reset_stretch import pocket_core_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 temp_reset,
    core_settings_if.reset_user  settings,
    output logic                 core_run
);

    hold_count_t hold_cnt;

    ////////////////////
    // hold counter
    ////////////////////
    always_ff @(posedge clk_sys) begin
        if (temp_reset || settings.restart) begin
            // reload and stop the core
            hold_cnt <= RESET_HOLD_CYCLES;
            core_run <= 1'b0;
        end else if (hold_cnt == '0) begin
            // hold done, core running
            core_run <= 1'b1;
        end else begin
            hold_cnt <= hold_cnt - 1'b1;
            core_run <= 1'b0;
        end
    end

endmodule

//--- bridge_reg_decode.sv
// Host bridge register file for the core settings.
// Decodes writes and reads at four addresses, holds the settings and
// returns read data one cycle after the read strobe.

`timescale 1ns/1ns

module bridge_reg_decode import pocket_core_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   temp_reset,
    input  bridge_addr_t           bridge_addr,
    input  logic                   bridge_rd,
    input  logic                   bridge_wr,
    input  bridge_data_t           bridge_wr_data,
    input  logic                   core_run,
    output bridge_data_t           bridge_rd_data,
    core_settings_if.decoder       settings
);

    ////////////////////
    // address decode
    ////////////////////
    logic hit_reset;
    logic hit_dip;
    logic hit_mode;
    logic hit_snac;
    logic addr_match;

    assign hit_reset  = (bridge_addr == ADDR_RESET);
    assign hit_dip    = (bridge_addr == ADDR_DIP);
    assign hit_mode   = (bridge_addr == ADDR_MODE);
    assign hit_snac   = (bridge_addr == ADDR_SNAC);
    // any of our four slots
    assign addr_match = hit_reset | hit_dip | hit_mode | hit_snac;

    ////////////////////
    // setting registers
    ////////////////////
    bridge_data_t   dip_reg;
    bridge_data_t   mode_reg;
    snac_settings_t snac_reg;

    always_ff @(posedge clk_sys) begin
        if (temp_reset) begin
            dip_reg  <= '0;
            mode_reg <= '0;
            snac_reg <= '0;
        end else if (bridge_wr) begin
            // full words kept for read-back
            if (hit_dip) begin
                dip_reg <= bridge_wr_data;
            end
            if (hit_mode) begin
                mode_reg <= bridge_wr_data;
            end
            // upper bits of the snac word are not stored
            if (hit_snac) begin
                snac_reg <= bridge_wr_data[13:0];
            end
        end
    end

    // reset command and dip change both restart the core
    always_ff @(posedge clk_sys) begin
        if (temp_reset) begin
            settings.restart <= 1'b0;
        end else begin
            settings.restart <= bridge_wr & (hit_reset | hit_dip);
        end
    end

    // bank 0 and 1 in the low bytes, mode in the low byte
    assign settings.dip_sw0   = dip_reg[7:0];
    assign settings.dip_sw1   = dip_reg[15:8];
    assign settings.core_mode = mode_reg[7:0];
    // type in 4:0, assignment in 9:6
    assign settings.snac_type   = snac_reg[4:0];
    assign settings.snac_assign = snac_reg[9:6];

    ////////////////////
    // read path
    ////////////////////
    bridge_data_t read_buffer;

    always_ff @(posedge clk_sys) begin
        if (temp_reset) begin
            read_buffer <= '0;
        end else if (bridge_rd) begin
            // other addresses leave the buffer alone
            if (hit_reset) begin
                read_buffer <= {31'd0, core_run};
            end else if (hit_dip) begin
                read_buffer <= dip_reg;
            end else if (hit_mode) begin
                read_buffer <= mode_reg;
            end else if (hit_snac) begin
                read_buffer <= {18'd0, snac_reg};
            end
        end
    end

    // unmapped addresses read as zero
    assign bridge_rd_data = addr_match ? read_buffer : '0;

endmodule

//--- player_input_if.sv
// Routed key and stick words for both players.
// Written by the controller router, read by the panel encoder.

`timescale 1ns/1ns

interface player_input_if import pocket_core_pkg::*; ();

    // player 1
    cont_key_t p1_key;
    cont_joy_t p1_joy;

    // player 2
    cont_key_t p2_key;
    cont_joy_t p2_joy;

    modport router (output p1_key, p1_joy, p2_key, p2_joy);

    modport encoder (input p1_key, p1_joy, p2_key, p2_joy);

endinterface

//--- core_settings_if.sv
// Decoded bridge settings and the core restart strobe.
// Driven by the register decode, read by the reset stretch and pad logic.

`timescale 1ns/1ns

interface core_settings_if import pocket_core_pkg::*; ();

    // dip banks and board mode, straight from the registers
    dip_t         dip_sw0;
    dip_t         dip_sw1;
    mode_t        core_mode;

    // snac fields of the stored settings word
    snac_type_t   snac_type;
    snac_assign_t snac_assign;

    // one cycle pulse, restarts the core reset hold
    logic         restart;

    modport decoder (
        output dip_sw0, dip_sw1, core_mode, snac_type, snac_assign, restart
    );

    modport reset_user (input restart);

    modport pad_user (input snac_type, snac_assign);

endinterface

//--- pocket_core_pkg.sv
// Shared widths, bridge register addresses and controller constants.
// Every RTL file of the pocket core front end imports this package.

package pocket_core_pkg;

    ////////////////////
    // host bridge
    ////////////////////
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // register map, one 32-bit slot each
    localparam bridge_addr_t ADDR_RESET = 32'hF000_0000;
    localparam bridge_addr_t ADDR_DIP   = 32'hF100_0000;
    localparam bridge_addr_t ADDR_MODE  = 32'hF200_0000;
    localparam bridge_addr_t ADDR_SNAC  = 32'hF700_0000;

    ////////////////////
    // core settings
    ////////////////////
    typedef logic [7:0]  dip_t;
    typedef logic [7:0]  mode_t;
    typedef logic [13:0] snac_settings_t;
    typedef logic [4:0]  snac_type_t;
    typedef logic [3:0]  snac_assign_t;

    // reset hold counter, wide enough for the hold count
    typedef logic [13:0] hold_count_t;
    localparam hold_count_t RESET_HOLD_CYCLES = 14'd8000;

    // type 0 means the adapter port is off
    localparam snac_type_t SNAC_DISABLED    = 5'h00;
    // dual-stick pad, left stick acts as d-pad
    localparam snac_type_t SNAC_ANALOG_TYPE = 5'h13;

    ////////////////////
    // controllers
    ////////////////////
    typedef logic [31:0] cont_key_t;
    typedef logic [31:0] cont_joy_t;
    typedef logic [15:0] pad_btn_t;
    typedef logic [3:0]  key_type_t;
    typedef logic [7:0]  stick_axis_t;

    // key word bits 31:28, analog capable pad
    localparam key_type_t KEY_TYPE_ANALOG = 4'h3;

    // centre position in every stick byte
    localparam cont_joy_t JOY_NEUTRAL = 32'h8080_8080;

    // dead zone limits around the centre
    localparam stick_axis_t STICK_LOW  = 8'h40;
    localparam stick_axis_t STICK_HIGH = 8'hC0;

    // button bit positions in the key word
    localparam int BTN_UP     = 0;
    localparam int BTN_DOWN   = 1;
    localparam int BTN_LEFT   = 2;
    localparam int BTN_RIGHT  = 3;
    localparam int BTN_A      = 4;
    localparam int BTN_B      = 5;
    localparam int BTN_SELECT = 14;
    localparam int BTN_START  = 15;

    // active low, coin start2 start1 shoot2 shoot up down left right
    typedef logic [8:0] control_panel_t;

endpackage
